// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_pkg::word_t     i_a,
    input  ex_pkg::word_t     i_b,
    input  logic [4:0]        i_shamt,
    input  ex_pkg::alu_ctrl_t i_ctrl,
    output ex_pkg::word_t     o_result
);

    import ex_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    // Compare results shared by SLT and SLTU
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb begin
        case (i_ctrl)
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_NOR:  o_result = ~(i_a | i_b);
            ALU_SLT:  o_result = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: o_result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            // Shifts act on the rt side with the amount chosen upstream
            ALU_SLL:  o_result = i_b << i_shamt;
            ALU_SRL:  o_result = i_b >> i_shamt;
            ALU_SRA: begin
                // Sign fill from bit 31
                o_result = word_t'($signed(i_b) >>> i_shamt);
            end
            ALU_LUI: begin
                o_result = {i_b[15:0], 16'h0000};
            end
            default: begin
                o_result = i_a + i_b;
            end
        endcase
    end

endmodule

// File: hdl/alu_control.sv
`timescale 1ns/1ps

module alu_control (
    input  ex_pkg::aluop_t    i_aluop,
    input  ex_pkg::opcode_t   i_opcode,
    input  ex_pkg::funct_t    i_funct,
    output ex_pkg::alu_ctrl_t o_ctrl,
    output logic              o_zero_ext,
    output logic              o_var_shift
);

    import ex_pkg::*;

    alu_ctrl_t funct_ctrl;
    alu_ctrl_t opcode_ctrl;

    //////////////////////////////
    // R-type decode
    //////////////////////////////
    always_comb begin
        case (i_funct)
            FN_ADD, FN_ADDU:  funct_ctrl = ALU_ADD;
            FN_SUB, FN_SUBU:  funct_ctrl = ALU_SUB;
            FN_AND:           funct_ctrl = ALU_AND;
            FN_OR:            funct_ctrl = ALU_OR;
            FN_XOR:           funct_ctrl = ALU_XOR;
            FN_NOR:           funct_ctrl = ALU_NOR;
            FN_SLT:           funct_ctrl = ALU_SLT;
            FN_SLTU:          funct_ctrl = ALU_SLTU;
            FN_SLL, FN_SLLV:  funct_ctrl = ALU_SLL;
            FN_SRL, FN_SRLV:  funct_ctrl = ALU_SRL;
            FN_SRA, FN_SRAV:  funct_ctrl = ALU_SRA;
            default:          funct_ctrl = ALU_ADD;
        endcase
    end

    //////////////////////////////
    // I-type decode
    //////////////////////////////
    always_comb begin
        case (i_opcode)
            OP_ADDI, OP_ADDIU: opcode_ctrl = ALU_ADD;
            OP_SLTI:           opcode_ctrl = ALU_SLT;
            OP_SLTIU:          opcode_ctrl = ALU_SLTU;
            OP_ANDI:           opcode_ctrl = ALU_AND;
            OP_ORI:            opcode_ctrl = ALU_OR;
            OP_XORI:           opcode_ctrl = ALU_XOR;
            OP_LUI:            opcode_ctrl = ALU_LUI;
            default:           opcode_ctrl = ALU_ADD;
        endcase
    end

    always_comb begin
        case (i_aluop)
            ALUOP_FUNCT:  o_ctrl = funct_ctrl;
            ALUOP_OPCODE: o_ctrl = opcode_ctrl;
            default:      o_ctrl = ALU_ADD;
        endcase
    end

    // Logical immediates are zero extended
    assign o_zero_ext = (i_aluop == ALUOP_OPCODE) &&
                        (i_opcode == OP_ANDI || i_opcode == OP_ORI || i_opcode == OP_XORI);

    // V shifts take the amount from rs
    assign o_var_shift = (i_aluop == ALUOP_FUNCT) &&
                         (i_funct == FN_SLLV || i_funct == FN_SRLV || i_funct == FN_SRAV);

endmodule

// File: hdl/ex_pkg.sv
package ex_pkg;

    //////////////////////////////
    // Widths and basic types
    //////////////////////////////
    localparam int DATA_W = 32;
    localparam int REG_W  = 5;
    localparam int OP_W   = 6;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [5:0]        funct_t;
    typedef logic [3:0]        alu_ctrl_t;
    typedef logic [1:0]        aluop_t;
    typedef logic [1:0]        fwd_sel_t;

    // ALU operation codes
    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_AND  = 4'd2;
    localparam alu_ctrl_t ALU_OR   = 4'd3;
    localparam alu_ctrl_t ALU_XOR  = 4'd4;
    localparam alu_ctrl_t ALU_NOR  = 4'd5;
    localparam alu_ctrl_t ALU_SLT  = 4'd6;
    localparam alu_ctrl_t ALU_SLTU = 4'd7;
    localparam alu_ctrl_t ALU_SLL  = 4'd8;
    localparam alu_ctrl_t ALU_SRL  = 4'd9;
    localparam alu_ctrl_t ALU_SRA  = 4'd10;
    localparam alu_ctrl_t ALU_LUI  = 4'd11;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    // R-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // ALU class and operand source selects
    localparam aluop_t ALUOP_ADD    = 2'b00;
    localparam aluop_t ALUOP_FUNCT  = 2'b10;
    localparam aluop_t ALUOP_OPCODE = 2'b11;

    localparam fwd_sel_t FWD_REG = 2'b00;
    localparam fwd_sel_t FWD_MEM = 2'b10;
    localparam fwd_sel_t FWD_WB  = 2'b01;

    //////////////////////////////
    // Pipeline structs
    //////////////////////////////
    typedef struct packed {
        logic   regdst;
        logic   alusrc;
        aluop_t aluop;
    } ex_ctrl_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        ex_ctrl_t ctrl;
    } issue_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    result;
    } mem_stage_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

// File: hdl/ex_top.sv
`timescale 1ns/1ps

module ex_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  ex_pkg::issue_t     i_issue,
    input  ex_pkg::wb_t        i_wb,
    output ex_pkg::mem_stage_t o_mem
);

    import ex_pkg::*;

    reg_idx_t src_rs;
    reg_idx_t src_rt;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    //////////////////////////////
    // Datapath
    //////////////////////////////
    execute_stage execute_stage_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_issue  (i_issue),
        .i_wb     (i_wb),
        .i_fwd_a  (fwd_a),
        .i_fwd_b  (fwd_b),
        .o_src_rs (src_rs),
        .o_src_rt (src_rt),
        .o_mem    (o_mem)
    );

    //////////////////////////////
    // Forwarding
    //////////////////////////////
    // Selects settle in the same cycle from the EX/MEM
    // register and the write-back bus
    forward_unit forward_unit_i (
        .i_rs    (src_rs),
        .i_rt    (src_rt),
        .i_mem   (o_mem),
        .i_wb    (i_wb),
        .o_fwd_a (fwd_a),
        .o_fwd_b (fwd_b)
    );

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  ex_pkg::issue_t     i_issue,
    input  ex_pkg::wb_t        i_wb,
    input  ex_pkg::fwd_sel_t   i_fwd_a,
    input  ex_pkg::fwd_sel_t   i_fwd_b,
    output ex_pkg::reg_idx_t   o_src_rs,
    output ex_pkg::reg_idx_t   o_src_rt,
    output ex_pkg::mem_stage_t o_mem
);

    import ex_pkg::*;

    issue_t     id_ex_q;
    mem_stage_t ex_mem_q;

    word_t     op_a;
    word_t     fwd_b_data;
    word_t     op_b;
    word_t     imm_ext;
    word_t     alu_result;
    alu_ctrl_t alu_ctrl;
    logic      zero_ext;
    logic      var_shift;
    logic [4:0] shamt;
    reg_idx_t  dest;

    // Three-way operand source select
    function automatic word_t select_operand(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        word_t val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    //////////////////////////////
    // ID/EX register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= i_issue;
        end
    end

    assign o_src_rs = id_ex_q.rs;
    assign o_src_rt = id_ex_q.rt;

    //////////////////////////////
    // Operand selection
    //////////////////////////////
    assign op_a       = select_operand(i_fwd_a, id_ex_q.rs_data, ex_mem_q.result, i_wb.data);
    assign fwd_b_data = select_operand(i_fwd_b, id_ex_q.rt_data, ex_mem_q.result, i_wb.data);

    // ANDI, ORI and XORI drop the sign extension
    assign imm_ext = zero_ext ? {16'h0000, id_ex_q.imm[15:0]} : id_ex_q.imm;
    assign op_b    = id_ex_q.ctrl.alusrc ? imm_ext : fwd_b_data;

    // Shamt field or rs bits 4 to 0
    assign shamt = var_shift ? op_a[4:0] : id_ex_q.imm[10:6];

    alu_control alu_control_i (
        .i_aluop     (id_ex_q.ctrl.aluop),
        .i_opcode    (id_ex_q.opcode),
        .i_funct     (id_ex_q.imm[5:0]),
        .o_ctrl      (alu_ctrl),
        .o_zero_ext  (zero_ext),
        .o_var_shift (var_shift)
    );

    alu alu_i (
        .i_a      (op_a),
        .i_b      (op_b),
        .i_shamt  (shamt),
        .i_ctrl   (alu_ctrl),
        .o_result (alu_result)
    );

    assign dest = id_ex_q.ctrl.regdst ? id_ex_q.rd : id_ex_q.rt;

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid  <= id_ex_q.valid;
            ex_mem_q.dest   <= dest;
            ex_mem_q.result <= alu_result;
        end
    end

    assign o_mem = ex_mem_q;

endmodule

// File: hdl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  ex_pkg::reg_idx_t   i_rs,
    input  ex_pkg::reg_idx_t   i_rt,
    input  ex_pkg::mem_stage_t i_mem,
    input  ex_pkg::wb_t        i_wb,
    output ex_pkg::fwd_sel_t   o_fwd_a,
    output ex_pkg::fwd_sel_t   o_fwd_b
);

    import ex_pkg::*;

    logic mem_live;
    logic wb_live;

    // r0 is hardwired, so a write to it never forwards
    assign mem_live = i_mem.valid && (i_mem.dest != '0);
    assign wb_live  = i_wb.valid && (i_wb.dest != '0);

    // Youngest producer has priority
    function automatic fwd_sel_t pick_source(input reg_idx_t src);
        fwd_sel_t sel;
        if (mem_live && (i_mem.dest == src)) begin
            sel = FWD_MEM;
        end else if (wb_live && (i_wb.dest == src)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    //////////////////////////////
    // Per-operand selects
    //////////////////////////////
    always_comb begin
        o_fwd_a = pick_source(i_rs);
        o_fwd_b = pick_source(i_rt);
    end

endmodule

// File: project.f
hdl/ex_pkg.sv
hdl/alu.sv
hdl/alu_control.sv
hdl/forward_unit.sv
hdl/execute_stage.sv
hdl/ex_top.sv
tb/ex_top_sva.sv
tb/ex_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert \
    -f project.f \
    --top-module ex_top_tb \
    -Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vex_top_tb" | tee "$LOG_FILE"

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail (see $LOG_FILE)"
    exit 1
fi

// File: tb/ex_top_sva.sv
`timescale 1ns/1ps

module ex_top_sva (
    input logic               i_clk,
    input logic               i_rst_n,
    input ex_pkg::issue_t     i_issue,
    input ex_pkg::wb_t        i_wb,
    input ex_pkg::mem_stage_t i_mem,
    input ex_pkg::fwd_sel_t   i_fwd_a,
    input ex_pkg::fwd_sel_t   i_fwd_b
);

    import ex_pkg::*;

    //////////////////////////////
    // Latency and reset
    //////////////////////////////
    // Issue sampled at edge k shows up in EX/MEM after edge k+1
    latency_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem.valid == $past(i_issue.valid, 2))
        else $error("o_mem.valid does not follow the issue valid by two edges");

    reset_valid: assert property (@(negedge i_clk) !i_rst_n |-> !i_mem.valid)
        else $error("o_mem.valid high while reset is asserted");

    //////////////////////////////
    // Forward selects
    //////////////////////////////
    fwd_a_mem: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_fwd_a == FWD_MEM) |-> (i_mem.valid && i_mem.dest != '0))
        else $error("operand A forwarded from an invalid or r0 EX/MEM entry");

    fwd_a_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_fwd_a == FWD_WB) |-> (i_wb.valid && i_wb.dest != '0))
        else $error("operand A forwarded from an invalid or r0 write-back");

    fwd_b_mem: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_fwd_b == FWD_MEM) |-> (i_mem.valid && i_mem.dest != '0))
        else $error("operand B forwarded from an invalid or r0 EX/MEM entry");

    fwd_b_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_fwd_b == FWD_WB) |-> (i_wb.valid && i_wb.dest != '0))
        else $error("operand B forwarded from an invalid or r0 write-back");

endmodule

bind ex_top ex_top_sva ex_top_sva_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_issue (i_issue),
    .i_wb    (i_wb),
    .i_mem   (o_mem),
    .i_fwd_a (fwd_a),
    .i_fwd_b (fwd_b)
);

// File: tb/ex_top_tb.sv
`timescale 1ns/1ps

module ex_top_tb;

    import ex_pkg::*;

    localparam int NUM_INSTR   = 600;
    localparam int DRAIN_LIMIT = 20;

    localparam funct_t R_FUNCTS [16] = '{
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV
    };
    localparam opcode_t I_OPCODES [8] = '{
        OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI
    };

    logic       i_clk;
    logic       i_rst_n;
    issue_t     i_issue;
    wb_t        i_wb;
    mem_stage_t o_mem;

    // Architectural file feeds rs_data and rt_data
    // Model file is updated in program order
    word_t       arch_rf [32];
    word_t       model_rf [32];
    wb_t         pending_wb;
    mem_stage_t  exp_q [$];
    logic [31:0] rng_state = 32'd59;
    int          errors = 0;
    int          checks = 0;
    int          guard;

    ex_top ex_top_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_issue (i_issue),
        .i_wb    (i_wb),
        .o_mem   (o_mem)
    );

    always #20 i_clk = ~i_clk;

    //////////////////////////////
    // Random numbers
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Mostly r0 to r3 so producers and consumers collide
    function automatic reg_idx_t pick_reg(input logic [31:0] r);
        return (r[2:0] != 3'd0) ? {3'd0, r[4:3]} : r[9:5];
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic word_t model_result(input issue_t w, input word_t a, input word_t b);
        word_t      sext;
        word_t      zext;
        logic [4:0] sh;
        word_t      r;
        sext = w.imm;
        zext = {16'h0000, w.imm[15:0]};
        sh   = w.imm[10:6];
        r    = '0;
        if (w.opcode == OP_RTYPE) begin
            // Variable shifts take rs bits 4 to 0
            if (w.imm[5:0] == FN_SLLV || w.imm[5:0] == FN_SRLV || w.imm[5:0] == FN_SRAV) begin
                sh = a[4:0];
            end
            case (w.imm[5:0])
                FN_ADD, FN_ADDU:  r = a + b;
                FN_SUB, FN_SUBU:  r = a - b;
                FN_AND:           r = a & b;
                FN_OR:            r = a | b;
                FN_XOR:           r = a ^ b;
                FN_NOR:           r = ~(a | b);
                FN_SLT:           r = {31'd0, $signed(a) < $signed(b)};
                FN_SLTU:          r = {31'd0, a < b};
                FN_SLL, FN_SLLV:  r = b << sh;
                FN_SRL, FN_SRLV:  r = b >> sh;
                FN_SRA, FN_SRAV:  r = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                default:          r = a + b;
            endcase
        end else begin
            case (w.opcode)
                OP_ADDI, OP_ADDIU: r = a + sext;
                OP_SLTI:           r = {31'd0, $signed(a) < $signed(sext)};
                OP_SLTIU:          r = {31'd0, a < sext};
                OP_ANDI:           r = a & zext;
                OP_ORI:            r = a | zext;
                OP_XORI:           r = a ^ zext;
                OP_LUI:            r = {w.imm[15:0], 16'h0000};
                default:           r = a + sext;
            endcase
        end
        return r;
    endfunction

    task automatic predict(input issue_t w, output mem_stage_t e);
        e.valid  = w.valid;
        e.dest   = w.ctrl.regdst ? w.rd : w.rt;
        e.result = model_result(w, model_rf[w.rs], model_rf[w.rt]);
        if (w.valid && e.dest != '0) begin
            model_rf[e.dest] = e.result;
        end
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////
    task automatic build_issue(output issue_t w);
        logic [31:0] r;
        logic [4:0]  op_idx;
        logic [15:0] imm16;
        reg_idx_t    rd;
        r = next_rand();
        w = '0;
        w.valid = (r[7:4] != 4'd0);
        op_idx  = r[12:8] % 5'd24;
        w.rs    = pick_reg(next_rand());
        w.rt    = pick_reg(next_rand());
        rd      = pick_reg(next_rand());
        w.rd    = rd;
        r       = next_rand();
        imm16   = r[31:16];
        if (op_idx < 5'd16) begin
            w.opcode     = OP_RTYPE;
            imm16        = {rd, r[4:0], R_FUNCTS[op_idx[3:0]]};
            w.ctrl.regdst = 1'b1;
            w.ctrl.alusrc = 1'b0;
            w.ctrl.aluop  = ALUOP_FUNCT;
        end else begin
            w.opcode     = I_OPCODES[op_idx[2:0]];
            w.ctrl.regdst = 1'b0;
            w.ctrl.alusrc = 1'b1;
            w.ctrl.aluop  = ALUOP_OPCODE;
        end
        // Occasional flip exercises the destination mux
        if (r[15:13] == 3'd0) begin
            w.ctrl.regdst = ~w.ctrl.regdst;
        end
        w.imm     = {{16{imm16[15]}}, imm16};
        w.rs_data = arch_rf[w.rs];
        w.rt_data = arch_rf[w.rt];
    endtask

    task automatic check_mem_output(input mem_stage_t e);
        checks++;
        if (o_mem.valid !== e.valid) begin
            errors++;
            $display("[FAIL] %0t o_mem.valid expected %0b actual %0b",
                     $time, e.valid, o_mem.valid);
        end
        if (e.valid && o_mem.dest !== e.dest) begin
            errors++;
            $display("[FAIL] %0t o_mem.dest expected %0d actual %0d", $time, e.dest, o_mem.dest);
        end
        if (e.valid && o_mem.result !== e.result) begin
            errors++;
            $display("[FAIL] %0t o_mem.result expected %h actual %h",
                     $time, e.result, o_mem.result);
        end
    endtask

    task automatic run_cycle(input logic issue_new);
        issue_t     w;
        mem_stage_t e;
        @(posedge i_clk);
        #2;
        // Last cycle's EX/MEM result goes out on the write-back bus
        i_wb = pending_wb;
        if (pending_wb.valid && pending_wb.dest != '0) begin
            arch_rf[pending_wb.dest] = pending_wb.data;
        end
        pending_wb.valid = o_mem.valid;
        pending_wb.dest  = o_mem.dest;
        pending_wb.data  = o_mem.result;
        if (exp_q.size() == 2 || (!issue_new && exp_q.size() > 0)) begin
            check_mem_output(exp_q.pop_front());
        end else begin
            checks++;
            if (o_mem.valid !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t o_mem.valid expected 0 actual %0b", $time, o_mem.valid);
            end
        end
        if (issue_new) begin
            build_issue(w);
            predict(w, e);
            exp_q.push_back(e);
            i_issue = w;
        end else begin
            i_issue = '0;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        i_clk      = 1'b0;
        i_rst_n    = 1'b0;
        i_issue    = '0;
        i_wb       = '0;
        pending_wb = '0;
        arch_rf[0]  = '0;
        model_rf[0] = '0;
        for (int i = 1; i < 32; i++) begin
            arch_rf[i]  = next_rand();
            model_rf[i] = arch_rf[i];
        end

        repeat (8) run_cycle(1'b0);
        i_rst_n = 1'b1;
        repeat (2) run_cycle(1'b0);

        for (int n = 0; n < NUM_INSTR; n++) begin
            run_cycle(1'b1);
        end

        // Drain until the pipeline output goes idle
        guard = 0;
        while ((exp_q.size() > 0 || o_mem.valid) && guard < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            guard++;
        end
        if (exp_q.size() > 0 || o_mem.valid) begin
            errors++;
            $display("Timeout: o_mem still busy after %0d drain cycles", guard);
        end
        run_cycle(1'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
